// ==== logic/tinker_pkg.sv ====
package tinker_pkg;

    localparam int xlen = 64; // data path width
    localparam int ilen = 32; // instruction width

    typedef logic [4:0]  reg_idx_t; // register number
    typedef logic [11:0] lit_t;     // literal field
    typedef logic [4:0]  opcode_t;

    // logic and shifts
    localparam opcode_t op_and    = 5'h00;
    localparam opcode_t op_or     = 5'h01;
    localparam opcode_t op_xor    = 5'h02;
    localparam opcode_t op_not    = 5'h03;
    localparam opcode_t op_shftr  = 5'h04;
    localparam opcode_t op_shftri = 5'h05;
    localparam opcode_t op_shftl  = 5'h06;
    localparam opcode_t op_shftli = 5'h07;

    // control flow
    localparam opcode_t op_br     = 5'h08; // pc = rd
    localparam opcode_t op_brr    = 5'h09; // pc += rd
    localparam opcode_t op_brr_l  = 5'h0a; // pc += sext(L) * 4
    localparam opcode_t op_brnz   = 5'h0b;
    localparam opcode_t op_brgt   = 5'h0e;
    localparam opcode_t op_halt   = 5'h0f;

    // data movement
    localparam opcode_t op_load   = 5'h10; // mov rd, (rs)(L)
    localparam opcode_t op_mov_rs = 5'h11;
    localparam opcode_t op_mov_l  = 5'h12;
    localparam opcode_t op_store  = 5'h13; // mov (rd)(L), rs

    // integer arithmetic
    localparam opcode_t op_add    = 5'h18;
    localparam opcode_t op_addi   = 5'h19;
    localparam opcode_t op_sub    = 5'h1a;
    localparam opcode_t op_subi   = 5'h1b;
    localparam opcode_t op_mul    = 5'h1c;

    localparam logic [ilen-1:0] nop_instr = 32'h8800_0000; // mov r0, r0

    // where an EX operand comes from
    typedef enum logic [1:0] {
        fwd_rf    = 2'd0,
        fwd_exmem = 2'd1,
        fwd_memwb = 2'd2
    } fwd_sel_t;

    typedef struct packed {
        logic reg_write;  // commit rd in WB
        logic mem_read;   // load in MEM
        logic mem_write;  // store in MEM
        logic mem_to_reg; // WB takes load data
        logic is_branch;
        logic halt;
    } ctrl_t;

endpackage

// ==== logic/unified_memory.sv ====
`timescale 1ns/1ps

module unified_memory
    import tinker_pkg::*;
#(
    parameter int mem_bytes = 512 * 1024
) (
    input  logic            clk,
    input  logic [31:0]     fetch_addr,
    output logic [ilen-1:0] fetch_instr,
    input  logic [31:0]     load_addr,
    output logic [xlen-1:0] load_data,
    input  logic            store_we,
    input  logic [31:0]     store_addr,
    input  logic [xlen-1:0] store_data,
    input  logic            prog_we,
    input  logic [31:0]     prog_addr,
    input  logic [ilen-1:0] prog_data
);

    logic [7:0] bytes [mem_bytes]; // little endian, byte addressed

    always_ff @(posedge clk) begin
        if (store_we) begin
            for (int i = 0; i < xlen / 8; i++) begin
                bytes[store_addr + i] <= store_data[8*i +: 8];
            end
        end else if (prog_we) begin
            // boot loader writes one word at a time
            for (int i = 0; i < ilen / 8; i++) begin
                bytes[prog_addr + i] <= prog_data[8*i +: 8];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < ilen / 8; i++) begin
            fetch_instr[8*i +: 8] = bytes[fetch_addr + i]; // IF word
        end
        for (int i = 0; i < xlen / 8; i++) begin
            load_data[8*i +: 8] = bytes[load_addr + i]; // MEM doubleword
        end
    end

    // the pipeline runs only nops while boot is loading
    assert property (@(posedge clk) !(store_we && prog_we))
        else $error("store and program write in the same cycle");

endmodule

// ==== logic/register_file.sv ====
`timescale 1ns/1ps

module register_file
    import tinker_pkg::*;
#(
    parameter logic [xlen-1:0] stack_top = 64'h8_0000
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            we,
    input  reg_idx_t        wr_idx,
    input  logic [xlen-1:0] wr_data,
    input  reg_idx_t        rd_idx,
    input  reg_idx_t        rs_idx,
    input  reg_idx_t        rt_idx,
    output logic [xlen-1:0] rd_val,
    output logic [xlen-1:0] rs_val,
    output logic [xlen-1:0] rt_val
);

    logic [xlen-1:0] regs [32];
    logic            wr_live; // write that really lands, r0 is fixed

    assign wr_live = we && (wr_idx != '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 31; i++) begin
                regs[i] <= '0;
            end
            regs[31] <= stack_top; // stack pointer
        end else if (wr_live) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // WB write shows through to ID in the same cycle
    assign rd_val = (wr_live && wr_idx == rd_idx) ? wr_data : regs[rd_idx];
    assign rs_val = (wr_live && wr_idx == rs_idx) ? wr_data : regs[rs_idx];
    assign rt_val = (wr_live && wr_idx == rt_idx) ? wr_data : regs[rt_idx];

    assert property (@(posedge clk) disable iff (reset) (rs_idx == '0) |-> (rs_val == '0))
        else $error("r0 read back nonzero");

endmodule

// ==== logic/decode_control.sv ====
`timescale 1ns/1ps

module decode_control
    import tinker_pkg::*;
(
    input  logic [ilen-1:0] instr,
    output opcode_t         opcode,
    output reg_idx_t        rd,
    output reg_idx_t        rs,
    output reg_idx_t        rt,
    output lit_t            lit,
    output ctrl_t           ctrl
);

    // fixed field layout
    assign opcode = instr[31:27];
    assign rd     = instr[26:22];
    assign rs     = instr[21:17];
    assign rt     = instr[16:12];
    assign lit    = instr[11:0];

    always_comb begin
        ctrl = '0; // unknown opcode flows as a bubble
        case (opcode)
            // everything that writes rd from the ALU
            op_add, op_addi, op_sub, op_subi, op_mul,
            op_and, op_or, op_xor, op_not,
            op_shftr, op_shftri, op_shftl, op_shftli,
            op_mov_rs, op_mov_l: begin
                ctrl.reg_write = 1'b1;
            end
            op_load: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            op_store: begin
                ctrl.mem_write = 1'b1;
            end
            op_br, op_brr, op_brr_l, op_brnz, op_brgt: begin
                ctrl.is_branch = 1'b1; // resolved in ID, no later effect
            end
            op_halt: begin
                ctrl.halt = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// ==== logic/branch_resolve.sv ====
`timescale 1ns/1ps

module branch_resolve
    import tinker_pkg::*;
(
    input  opcode_t         opcode,
    input  logic [31:0]     pc,
    input  lit_t            lit,
    input  logic [xlen-1:0] rd_val,
    input  logic [xlen-1:0] rs_val,
    input  logic [xlen-1:0] rt_val,
    output logic            take_branch,
    output logic [31:0]     branch_target
);

    logic [31:0] lit_off; // word offset for brr L

    assign lit_off = {{18{lit[11]}}, lit, 2'b00};

    always_comb begin
        take_branch   = 1'b0;
        branch_target = pc + 32'd4; // fall through
        case (opcode)
            op_br: begin
                take_branch   = 1'b1;
                branch_target = rd_val[31:0];
            end
            op_brr: begin
                take_branch   = 1'b1;
                branch_target = pc + rd_val[31:0];
            end
            op_brr_l: begin
                take_branch   = 1'b1;
                branch_target = pc + lit_off;
            end
            op_brnz: begin
                take_branch   = (rs_val != '0);
                branch_target = take_branch ? rd_val[31:0] : pc + 32'd4;
            end
            op_brgt: begin
                take_branch   = ($signed(rs_val) > $signed(rt_val)); // signed compare
                branch_target = take_branch ? rd_val[31:0] : pc + 32'd4;
            end
            default: begin
                take_branch = 1'b0;
            end
        endcase
    end

endmodule

// ==== logic/hazard_forward.sv ====
`timescale 1ns/1ps

module hazard_forward
    import tinker_pkg::*;
(
    input  logic     idex_mem_read,
    input  reg_idx_t idex_rd,
    input  reg_idx_t ifid_rs,
    input  reg_idx_t ifid_rt,
    input  reg_idx_t ifid_rd,
    input  reg_idx_t exmem_rd,
    input  logic     exmem_reg_write,
    input  reg_idx_t memwb_rd,
    input  logic     memwb_reg_write,
    input  reg_idx_t idex_rs,
    input  reg_idx_t idex_rt,
    input  reg_idx_t idex_rd_src,
    output logic     stall,
    output fwd_sel_t sel_rs,
    output fwd_sel_t sel_rt,
    output fwd_sel_t sel_rd
);

    // youngest producer wins, r0 never forwarded
    function automatic fwd_sel_t pick(input reg_idx_t src);
        if (src == '0) return fwd_rf;
        if (exmem_reg_write && exmem_rd == src) return fwd_exmem;
        if (memwb_reg_write && memwb_rd == src) return fwd_memwb;
        return fwd_rf;
    endfunction

    always_comb begin
        sel_rs = pick(idex_rs);
        sel_rt = pick(idex_rt);
        sel_rd = pick(idex_rd_src); // rd as a source operand
    end

    // load data is only ready after MEM, one bubble covers it
    assign stall = idex_mem_read && (idex_rd != '0) &&
                   (idex_rd == ifid_rs || idex_rd == ifid_rt || idex_rd == ifid_rd);

endmodule

// ==== logic/int_alu.sv ====
`timescale 1ns/1ps

module int_alu
    import tinker_pkg::*;
(
    input  opcode_t         opcode,
    input  logic [xlen-1:0] rd_val,
    input  logic [xlen-1:0] rs_val,
    input  logic [xlen-1:0] rt_val,
    input  lit_t            lit,
    output logic [xlen-1:0] result
);

    logic [xlen-1:0] lit_z; // immediate arithmetic
    logic [xlen-1:0] lit_s; // address offsets

    assign lit_z = {{(xlen-12){1'b0}}, lit};
    assign lit_s = {{(xlen-12){lit[11]}}, lit};

    always_comb begin
        case (opcode)
            op_add:    result = rs_val + rt_val;
            op_addi:   result = rd_val + lit_z;
            op_sub:    result = rs_val - rt_val;
            op_subi:   result = rd_val - lit_z;
            op_mul:    result = rs_val * rt_val; // low 64 bits
            op_and:    result = rs_val & rt_val;
            op_or:     result = rs_val | rt_val;
            op_xor:    result = rs_val ^ rt_val;
            op_not:    result = ~rs_val;
            op_shftr:  result = rs_val >> rt_val; // logical
            op_shftri: result = rd_val >> lit;
            op_shftl:  result = rs_val << rt_val;
            op_shftli: result = rd_val << lit;
            op_mov_rs: result = rs_val;
            op_mov_l:  result = {rd_val[xlen-1:12], lit}; // only low 12 bits change
            op_load:   result = rs_val + lit_s; // load address
            op_store:  result = rd_val + lit_s; // store address
            default:   result = '0;
        endcase
    end

endmodule

// ==== logic/tinker_core.sv ====
`timescale 1ns/1ps

module tinker_core
    import tinker_pkg::*;
#(
    parameter int              mem_bytes     = 512 * 1024,
    parameter logic [31:0]     pc_reset_addr = 32'h2000,
    parameter logic [xlen-1:0] stack_top     = 64'h8_0000
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            boot,
    input  logic            prog_we,
    input  logic [31:0]     prog_addr,
    input  logic [31:0]     prog_data,
    output logic            hlt,
    output logic            wb_valid,
    output reg_idx_t        wb_rd,
    output logic [xlen-1:0] wb_data
);

    typedef struct packed {
        opcode_t op;
        ctrl_t ctrl;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
        lit_t lit;
        logic [xlen-1:0] rd_val;
        logic [xlen-1:0] rs_val;
        logic [xlen-1:0] rt_val;
    } idex_t;

    typedef struct packed {
        ctrl_t ctrl;
        reg_idx_t rd;
        logic [xlen-1:0] alu;
        logic [xlen-1:0] other; // store data in EX/MEM, load data in MEM/WB
    } stage_t;

    logic [31:0]     pc_f;
    logic [31:0]     ifid_pc;
    logic [ilen-1:0] ifid_instr;
    logic [ilen-1:0] fetch_instr;
    opcode_t         id_op;
    reg_idx_t        id_rd;
    reg_idx_t        id_rs;
    reg_idx_t        id_rt;
    lit_t            id_lit;
    ctrl_t           id_ctrl;
    logic [xlen-1:0] rf_rd_val;
    logic [xlen-1:0] rf_rs_val;
    logic [xlen-1:0] rf_rt_val;
    logic            take_branch;
    logic [31:0]     branch_target;
    logic            stall;
    fwd_sel_t        sel_rs;
    fwd_sel_t        sel_rt;
    fwd_sel_t        sel_rd;
    logic [xlen-1:0] ex_rs;
    logic [xlen-1:0] ex_rt;
    logic [xlen-1:0] ex_rd;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] load_data;
    logic            rf_we;
    logic            halt_q;
    idex_t           idex;
    stage_t          exmem;
    stage_t          memwb;

    // fetch held at reset address during boot, frozen once halted
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc_f       <= pc_reset_addr;
            ifid_pc    <= '0;
            ifid_instr <= nop_instr;
        end else if (boot) begin
            pc_f       <= pc_reset_addr;
            ifid_instr <= nop_instr;
        end else if (!hlt && !stall) begin // stall beats a redirect
            if (id_ctrl.is_branch && take_branch) begin
                pc_f       <= branch_target;
                ifid_instr <= nop_instr; // squash the wrong-path fetch
            end else begin
                pc_f       <= pc_f + 32'd4;
                ifid_pc    <= pc_f;
                ifid_instr <= fetch_instr;
            end
        end
    end

    decode_control i_decode (
        .instr(ifid_instr), .opcode(id_op), .rd(id_rd), .rs(id_rs), .rt(id_rt),
        .lit(id_lit), .ctrl(id_ctrl)
    );

    register_file #(.stack_top(stack_top)) i_regs (
        .clk(clk), .reset(reset), .we(rf_we), .wr_idx(memwb.rd), .wr_data(wb_data),
        .rd_idx(id_rd), .rs_idx(id_rs), .rt_idx(id_rt),
        .rd_val(rf_rd_val), .rs_val(rf_rs_val), .rt_val(rf_rt_val)
    );

    // branch operands come straight from the register file
    branch_resolve i_branch (
        .opcode(id_op), .pc(ifid_pc), .lit(id_lit), .rd_val(rf_rd_val),
        .rs_val(rf_rs_val), .rt_val(rf_rt_val),
        .take_branch(take_branch), .branch_target(branch_target)
    );

    hazard_forward i_hazard (
        .idex_mem_read(idex.ctrl.mem_read), .idex_rd(idex.rd),
        .ifid_rs(id_rs), .ifid_rt(id_rt), .ifid_rd(id_rd),
        .exmem_rd(exmem.rd), .exmem_reg_write(exmem.ctrl.reg_write),
        .memwb_rd(memwb.rd), .memwb_reg_write(memwb.ctrl.reg_write),
        .idex_rs(idex.rs), .idex_rt(idex.rt), .idex_rd_src(idex.rd),
        .stall(stall), .sel_rs(sel_rs), .sel_rt(sel_rt), .sel_rd(sel_rd)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            idex <= '0;
        end else if (stall) begin
            idex <= '0; // bubble
        end else begin
            idex <= '{op: id_op, ctrl: id_ctrl, rd: id_rd, rs: id_rs, rt: id_rt,
                      lit: id_lit, rd_val: rf_rd_val, rs_val: rf_rs_val, rt_val: rf_rt_val};
        end
    end

    function automatic logic [xlen-1:0] fwd_mux(input fwd_sel_t sel,
                                                input logic [xlen-1:0] base);
        case (sel)
            fwd_exmem: return exmem.alu;
            fwd_memwb: return wb_data;
            default:   return base;
        endcase
    endfunction

    always_comb begin
        ex_rs = fwd_mux(sel_rs, idex.rs_val);
        ex_rt = fwd_mux(sel_rt, idex.rt_val);
        ex_rd = fwd_mux(sel_rd, idex.rd_val); // store base, immediates, mov L
    end

    int_alu i_alu (
        .opcode(idex.op), .rd_val(ex_rd), .rs_val(ex_rs), .rt_val(ex_rt),
        .lit(idex.lit), .result(alu_result)
    );

    unified_memory #(.mem_bytes(mem_bytes)) i_mem (
        .clk(clk), .fetch_addr(pc_f), .fetch_instr(fetch_instr),
        .load_addr(exmem.alu[31:0]), .load_data(load_data),
        .store_we(exmem.ctrl.mem_write && !hlt), .store_addr(exmem.alu[31:0]),
        .store_data(exmem.other),
        .prog_we(prog_we && boot && !reset), .prog_addr(prog_addr), .prog_data(prog_data)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exmem  <= '0;
            memwb  <= '0;
            halt_q <= 1'b0;
        end else begin
            exmem <= '{ctrl: idex.ctrl, rd: idex.rd, alu: alu_result, other: ex_rs};
            memwb <= '{ctrl: exmem.ctrl, rd: exmem.rd, alu: exmem.alu, other: load_data};
            if (memwb.ctrl.halt) begin
                halt_q <= 1'b1; // sticky until reset
            end
        end
    end

    // nothing younger than the halt commits
    assign hlt      = halt_q || memwb.ctrl.halt;
    assign wb_data  = memwb.ctrl.mem_to_reg ? memwb.other : memwb.alu;
    assign rf_we    = memwb.ctrl.reg_write && !hlt;
    assign wb_rd    = memwb.rd;
    assign wb_valid = rf_we && (memwb.rd != '0);

    assert property (@(posedge clk) disable iff (reset) hlt |=> hlt)
        else $error("hlt dropped before reset");

endmodule

// ==== verification/tinker_tb.sv ====
`timescale 1ns/1ps

module tinker_tb;

    logic        clk;
    logic        reset;
    logic        boot;
    logic        prog_we;
    logic [31:0] prog_addr;
    logic [31:0] prog_data;
    logic        hlt;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [63:0] wb_data;

    // current test as read from the stimulus file
    string       test_name;
    logic [31:0] prog_addr_q [$];
    logic [31:0] prog_word_q [$];
    logic [4:0]  exp_rd_q [$];   // writeback trace in commit order
    logic [63:0] exp_data_q [$];

    int errors;       // mismatches over the whole run
    int tests_run;
    int tests_failed;
    int cycles;       // cycles since boot dropped
    int cycle_limit;  // zero while no program runs

    tinker_core #(
        .mem_bytes(512 * 1024),
        .pc_reset_addr(32'h2000),
        .stack_top(64'h8_0000)
    ) i_dut (
        .clk(clk), .reset(reset), .boot(boot), .prog_we(prog_we),
        .prog_addr(prog_addr), .prog_data(prog_data), .hlt(hlt),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period
    end

    // program that never halts ends the run here
    initial begin
        wait (cycle_limit > 0 && cycles > cycle_limit);
        $display("test %s timed out waiting for hlt after %0d cycles", test_name, cycles);
        $display("Checks failed");
        $finish;
    end

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            errors++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic run_test();
        int errors_before;
        int pulses;      // wb_valid pulses seen
        int tail;        // cycles watched after hlt
        errors_before = errors;
        pulses        = 0;
        tail          = 0;
        @(posedge clk);
        reset <= 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        boot  <= 1'b1; // fetch parked at the reset address
        foreach (prog_addr_q[i]) begin
            prog_we   <= 1'b1;
            prog_addr <= prog_addr_q[i];
            prog_data <= prog_word_q[i];
            @(posedge clk);
        end
        prog_we     <= 1'b0;
        boot        <= 1'b0; // first fetch on the next edge
        cycles      = 0;
        cycle_limit = 20 * prog_addr_q.size() + 50;
        // outputs settle after the rising edge, look at them mid cycle
        do begin
            @(negedge clk);
            cycles++;
            if (hlt) begin
                tail++; // keep watching, nothing may commit now
            end
            if (wb_valid) begin
                if (pulses < exp_rd_q.size()) begin
                    check_value($sformatf("wb_rd of writeback %0d", pulses),
                                wb_rd, exp_rd_q[pulses]);
                    check_value($sformatf("wb_data of writeback %0d", pulses),
                                wb_data, exp_data_q[pulses]);
                end
                pulses++;
            end
        end while (tail < 5);
        cycle_limit = 0;
        check_value("writeback count", pulses, exp_rd_q.size());
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, errors - errors_before);
        end else begin
            $display("test %s ok, %0d writebacks", test_name, pulses);
        end
    endtask

    initial begin
        int          fd;
        string       line;
        logic [63:0] field_a;
        logic [63:0] field_b;
        reset     = 1'b1; // first test releases it
        boot      = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        fd = $fopen("verification/tinker_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/tinker_stimulus.txt");
            $display("Checks failed");
            $finish;
        end else begin
            while ($fgets(line, fd) > 0) begin
                case (line.getc(0))
                    "T": begin
                        void'($sscanf(line, "T %s", test_name));
                        prog_addr_q.delete();
                        prog_word_q.delete();
                        exp_rd_q.delete();
                        exp_data_q.delete();
                    end
                    "P": begin
                        void'($sscanf(line, "P %h %h", field_a, field_b));
                        prog_addr_q.push_back(field_a[31:0]);
                        prog_word_q.push_back(field_b[31:0]);
                    end
                    "E": begin
                        void'($sscanf(line, "E %h %h", field_a, field_b));
                        exp_rd_q.push_back(field_a[4:0]);
                        exp_data_q.push_back(field_b);
                    end
                    "X": run_test();
                    default: begin
                        // comment or blank line
                    end
                endcase
            end
            $fclose(fd);
            $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
            if (errors == 0 && tests_run > 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

endmodule

// ==== verification/tinker_stimulus.txt ====
# T test_name | P word_address instruction | E rd expected_wb_data | X runs the test
# numbers in hex, E lines in commit order, text after the fields is ignored
T alu_ops
P 2000 90400123  mov r1, 0x123
P 2004 908000F0  mov r2, 0x0f0
P 2008 C0C22000  add r3, r1, r2
P 200C D1022000  sub r4, r1, r2
P 2010 E1422000  mul r5, r1, r2
P 2014 01822000  and r6, r1, r2
P 2018 11C22000  xor r7, r1, r2
P 201C 1A020000  not r8, r1
P 2020 38400004  shftli r1, 4
P 2024 32424000  shftl r9, r1, r4
P 2028 22924000  shftr r10, r9, r4
P 202C 29400004  shftri r5, 4
P 2030 C8C00010  addi r3, 0x10
P 2034 D9000003  subi r4, 3
P 2038 8AC60000  mov r11, r3
P 203C 920005A5  mov r8, 0x5a5
P 2040 78000000  halt
E 01 123
E 02 F0
E 03 213
E 04 33
E 05 110D0
E 06 20
E 07 1D3
E 08 FFFFFFFFFFFFFEDC
E 01 1230
E 09 9180000000000000
E 0A 1230
E 05 110D
E 03 223
E 04 30
E 0B 223
E 08 FFFFFFFFFFFFF5A5
X
T forwarding
P 2000 90400005  mov r1, 5
P 2004 C0821000  add r2, r1, r1
P 2008 C8800001  addi r2, 1
P 200C C0C41000  add r3, r2, r1
P 2010 78000000  halt
E 01 5
E 02 A
E 02 B
E 03 10
X
T load_use
P 2000 904007AB  mov r1, 0x7ab
P 2004 18820000  not r2, r1
P 2008 90C00100  mov r3, 0x100
P 200C 98C40008  mov (r3)(8), r2
P 2010 81060008  mov r4, (r3)(8)
P 2014 C1481000  add r5, r4, r1
P 2018 78000000  halt
E 01 7AB
E 02 FFFFFFFFFFFFF854
E 03 100
E 04 FFFFFFFFFFFFF854
E 05 FFFFFFFFFFFFFFFF
X
T branches
P 2000 90400403  mov r1, 0x403
P 2004 38400003  shftli r1, 3
P 2008 90800005  mov r2, 5
P 200C 18C00000  not r3, r0
P 2010 40400000  br r1
P 2014 91000111  mov r4, 0x111
P 2018 C840001C  addi r1, 0x1c
P 201C 50000002  brr 2
P 2020 91400555  mov r5, 0x555
P 2024 58400000  brnz r1, r0
P 2028 91800066  mov r6, 0x66
P 202C 70443000  brgt r1, r2, r3
P 2030 91400777  mov r5, 0x777
P 2034 78000000  halt
E 01 403
E 01 2018
E 02 5
E 03 FFFFFFFFFFFFFFFF
E 01 2034
E 06 66
X
T r0_r31_halt
P 2000 90000055  mov r0, 0x55
P 2004 C07E0000  add r1, r31, r0
P 2008 C0021000  add r0, r1, r1
P 200C 88800000  mov r2, r0
P 2010 78000000  halt
P 2014 90C00003  mov r3, 3
P 2018 C1021000  add r4, r1, r1
E 01 80000
E 02 0
X

// ==== tb.f ====
logic/tinker_pkg.sv
logic/unified_memory.sv
logic/register_file.sv
logic/decode_control.sv
logic/branch_resolve.sv
logic/hazard_forward.sv
logic/int_alu.sv
logic/tinker_core.sv
verification/tinker_tb.sv

// ==== Bender.yml ====
package:
  name: tinker_core

sources:
  - logic/tinker_pkg.sv
  - logic/unified_memory.sv
  - logic/register_file.sv
  - logic/decode_control.sv
  - logic/branch_resolve.sv
  - logic/hazard_forward.sv
  - logic/int_alu.sv
  - logic/tinker_core.sv
  - target: test
    files:
      - verification/tinker_tb.sv
